// ==== src/rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0] reg_addr_t;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_src_e;
  typedef enum logic [1:0] {RES_ALU, RES_DATA, RES_PC_PLUS_4} result_src_e;
  typedef enum logic [1:0] {FWD_NONE, FWD_MEMORY, FWD_WRITEBACK} fwd_e;

  // Branch funct3 values
  localparam logic [2:0] BR_EQ = 3'b000;
  localparam logic [2:0] BR_NE = 3'b001;
  localparam logic [2:0] BR_LT = 3'b100;
  localparam logic [2:0] BR_GE = 3'b101;

  typedef struct packed {
    logic        reg_write;
    logic        mem_write;
    logic        branch;
    logic        jump;
    logic        alu_src_b_imm;
    alu_op_e     alu_op;
    result_src_e result_src;
    logic [2:0]  branch_cond;
  } ctrl_t;

  typedef struct packed {
    xlen_t instr;
    xlen_t pc;
    xlen_t pc_plus_4;
  } fd_t;

  typedef struct packed {
    ctrl_t     ctrl;
    xlen_t     rd1;
    xlen_t     rd2;
    xlen_t     imm;
    xlen_t     pc;
    xlen_t     pc_plus_4;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
  } de_t;

  typedef struct packed {
    logic        reg_write;
    logic        mem_write;
    result_src_e result_src;
    xlen_t       alu_result;
    xlen_t       write_data;
    xlen_t       pc_plus_4;
    reg_addr_t   rd;
  } em_t;

  typedef struct packed {
    logic        reg_write;
    result_src_e result_src;
    xlen_t       alu_result;
    xlen_t       read_data;
    xlen_t       pc_plus_4;
    reg_addr_t   rd;
  } mw_t;

  // addi x0, x0, 0
  localparam xlen_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== src/stage_reg.sv ====
module stage_reg #(
  parameter type payload_t = logic,
  parameter payload_t FLUSH_VALUE = '0
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     stall,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // Flush beats stall so a redirect squashes a held stage
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      q <= FLUSH_VALUE;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

// ==== src/decoder.sv ====
module decoder (
  input  rv_pkg::xlen_t instr,
  output rv_pkg::ctrl_t ctrl,
  output rv_pkg::xlen_t imm
);
  import rv_pkg::*;

  logic [2:0] funct3;
  logic       funct7_alt;
  imm_src_e   imm_src;

  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
    alu_op_e op;
    case (f3)
      3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign funct3     = instr[14:12];
  assign funct7_alt = instr[30];

  always_comb begin
    ctrl    = '0;
    imm_src = IMM_I;
    case (instr[6:0])
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_decode(funct3, funct7_alt, 1'b1);
      end
      OPC_OP_IMM: begin
        ctrl.reg_write     = 1'b1;
        ctrl.alu_src_b_imm = 1'b1;
        ctrl.alu_op        = alu_decode(funct3, funct7_alt, 1'b0);
      end
      OPC_LUI: begin
        imm_src            = IMM_U;
        ctrl.reg_write     = 1'b1;
        ctrl.alu_src_b_imm = 1'b1;
        ctrl.alu_op        = ALU_PASS_B;
      end
      OPC_LOAD: begin
        // Word access only
        if (funct3 == 3'b010) begin
          ctrl.reg_write     = 1'b1;
          ctrl.alu_src_b_imm = 1'b1;
          ctrl.result_src    = RES_DATA;
        end
      end
      OPC_STORE: begin
        imm_src = IMM_S;
        if (funct3 == 3'b010) begin
          ctrl.mem_write     = 1'b1;
          ctrl.alu_src_b_imm = 1'b1;
        end
      end
      OPC_BRANCH: begin
        imm_src = IMM_B;
        if (funct3 inside {BR_EQ, BR_NE, BR_LT, BR_GE}) begin
          ctrl.branch      = 1'b1;
          ctrl.alu_op      = ALU_SUB;
          ctrl.branch_cond = funct3;
        end
      end
      OPC_JAL: begin
        imm_src         = IMM_J;
        ctrl.reg_write  = 1'b1;
        ctrl.jump       = 1'b1;
        ctrl.result_src = RES_PC_PLUS_4;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (imm_src)
      IMM_I:   imm = {{20{instr[31]}}, instr[31:20]};
      IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      IMM_U:   imm = {instr[31:12], 12'b0};
      IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

// ==== src/reg_file.sv ====
module reg_file (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::xlen_t     rd1,
  output rv_pkg::xlen_t     rd2,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::xlen_t     wd,
  input  logic              we
);
  import rv_pkg::*;

  // x0 has no storage
  xlen_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst_n && we && rd != '0) begin
      regs[rd] <= wd;
    end
  end

  // Same-cycle write is visible to decode
  assign rd1 = (rs1 == '0) ? '0 : (we && rs1 == rd) ? wd : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : (we && rs2 == rd) ? wd : regs[rs2];

endmodule

// ==== src/execute_unit.sv ====
module execute_unit (
  input  rv_pkg::de_t   de,
  input  rv_pkg::fwd_e  fwd_a,
  input  rv_pkg::fwd_e  fwd_b,
  input  rv_pkg::xlen_t result_m,
  input  rv_pkg::xlen_t result_w,
  output rv_pkg::xlen_t alu_result,
  output rv_pkg::xlen_t write_data,
  output logic          pc_src,
  output rv_pkg::xlen_t pc_jump
);
  import rv_pkg::*;

  xlen_t src_a;
  xlen_t src_b_reg;
  xlen_t src_b;
  logic  zero;
  logic  neg;
  logic  overflow;
  logic  cond;

  function automatic xlen_t fwd_mux(input fwd_e sel, input xlen_t reg_val,
                                    input xlen_t mem_val, input xlen_t wb_val);
    case (sel)
      FWD_MEMORY:    return mem_val;
      FWD_WRITEBACK: return wb_val;
      default:       return reg_val;
    endcase
  endfunction

  assign src_a      = fwd_mux(fwd_a, de.rd1, result_m, result_w);
  assign src_b_reg  = fwd_mux(fwd_b, de.rd2, result_m, result_w);
  assign src_b      = de.ctrl.alu_src_b_imm ? de.imm : src_b_reg;
  assign write_data = src_b_reg;

  always_comb begin
    case (de.ctrl.alu_op)
      ALU_SUB:    alu_result = src_a - src_b;
      ALU_AND:    alu_result = src_a & src_b;
      ALU_OR:     alu_result = src_a | src_b;
      ALU_XOR:    alu_result = src_a ^ src_b;
      ALU_SLT:    alu_result = xlen_t'($signed(src_a) < $signed(src_b));
      ALU_SLTU:   alu_result = xlen_t'(src_a < src_b);
      ALU_SLL:    alu_result = src_a << src_b[4:0];
      ALU_SRL:    alu_result = src_a >> src_b[4:0];
      ALU_SRA:    alu_result = $signed(src_a) >>> src_b[4:0];
      ALU_PASS_B: alu_result = src_b;
      default:    alu_result = src_a + src_b;
    endcase
  end

  // Flags are meaningful for the subtract that branches use
  assign zero     = (alu_result == '0);
  assign neg      = alu_result[XLEN-1];
  assign overflow = (src_a[XLEN-1] ^ src_b[XLEN-1]) & (alu_result[XLEN-1] ^ src_a[XLEN-1]);

  always_comb begin
    case (de.ctrl.branch_cond)
      BR_EQ:   cond = zero;
      BR_NE:   cond = !zero;
      BR_LT:   cond = neg ^ overflow;
      BR_GE:   cond = !(neg ^ overflow);
      default: cond = 1'b0;
    endcase
  end

  assign pc_src  = de.ctrl.jump | (de.ctrl.branch & cond);
  assign pc_jump = de.pc + de.imm;

endmodule

// ==== src/hazard_unit.sv ====
module hazard_unit (
  input  rv_pkg::reg_addr_t   rs1_d,
  input  rv_pkg::reg_addr_t   rs2_d,
  input  rv_pkg::reg_addr_t   rs1_e,
  input  rv_pkg::reg_addr_t   rs2_e,
  input  rv_pkg::reg_addr_t   rd_e,
  input  rv_pkg::reg_addr_t   rd_m,
  input  rv_pkg::reg_addr_t   rd_w,
  input  rv_pkg::result_src_e result_src_e,
  input  logic                reg_write_m,
  input  logic                reg_write_w,
  input  logic                pc_src,
  output rv_pkg::fwd_e        fwd_a,
  output rv_pkg::fwd_e        fwd_b,
  output logic                stall_f,
  output logic                stall_d,
  output logic                flush_d,
  output logic                flush_e
);
  import rv_pkg::*;

  logic load_use;

  // Youngest producer wins
  function automatic fwd_e fwd_select(input reg_addr_t rs, input reg_addr_t m_rd,
                                      input logic m_we, input reg_addr_t w_rd,
                                      input logic w_we);
    if (rs == '0) return FWD_NONE;
    if (m_we && m_rd == rs) return FWD_MEMORY;
    if (w_we && w_rd == rs) return FWD_WRITEBACK;
    return FWD_NONE;
  endfunction

  assign fwd_a = fwd_select(rs1_e, rd_m, reg_write_m, rd_w, reg_write_w);
  assign fwd_b = fwd_select(rs2_e, rd_m, reg_write_m, rd_w, reg_write_w);

  assign load_use = (result_src_e == RES_DATA) && (rd_e != '0) &&
                    (rd_e == rs1_d || rd_e == rs2_d);

  assign stall_f = load_use & ~pc_src;
  assign stall_d = load_use & ~pc_src;
  assign flush_d = pc_src;
  assign flush_e = pc_src | load_use;

endmodule

// ==== src/rv_core.sv ====
module rv_core (
  input  logic          clk,
  input  logic          rst_n,
  output rv_pkg::xlen_t instr_addr,
  input  rv_pkg::xlen_t instr_data,
  output rv_pkg::xlen_t data_addr,
  output rv_pkg::xlen_t data_wdata,
  output logic          data_wenable,
  input  rv_pkg::xlen_t data_rdata
);
  import rv_pkg::*;

  localparam fd_t FD_FLUSH = '{instr: NOP_INSTR, pc: '0, pc_plus_4: '0};

  xlen_t     pc_f;
  xlen_t     pc_next_f;
  xlen_t     pc_plus_4_f;
  fd_t       fd_in;
  fd_t       fd_q;
  de_t       de_in;
  de_t       de_q;
  em_t       em_in;
  em_t       em_q;
  mw_t       mw_in;
  mw_t       mw_q;
  ctrl_t     ctrl_d;
  xlen_t     imm_d;
  xlen_t     rd1_d;
  xlen_t     rd2_d;
  reg_addr_t rs1_d;
  reg_addr_t rs2_d;
  xlen_t     alu_result_e;
  xlen_t     write_data_e;
  logic      pc_src;
  xlen_t     pc_jump;
  xlen_t     result_m;
  xlen_t     result_w;
  fwd_e      fwd_a;
  fwd_e      fwd_b;
  logic      stall_f;
  logic      stall_d;
  logic      flush_d;
  logic      flush_e;

  // Fetch with static not-taken
  assign pc_plus_4_f = pc_f + 32'd4;
  assign pc_next_f   = pc_src ? pc_jump : pc_plus_4_f;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_f <= '0;
    end else if (!stall_f) begin
      pc_f <= pc_next_f;
    end
  end

  assign instr_addr = pc_f;
  assign fd_in      = '{instr: instr_data, pc: pc_f, pc_plus_4: pc_plus_4_f};

  stage_reg #(.payload_t(fd_t), .FLUSH_VALUE(FD_FLUSH)) fd_reg (
    .clk(clk), .rst_n(rst_n), .stall(stall_d), .flush(flush_d), .d(fd_in), .q(fd_q)
  );

  // Decode
  assign rs1_d = fd_q.instr[19:15];
  assign rs2_d = fd_q.instr[24:20];

  decoder decoder_i (.instr(fd_q.instr), .ctrl(ctrl_d), .imm(imm_d));

  reg_file reg_file_i (
    .clk(clk), .rst_n(rst_n), .rs1(rs1_d), .rs2(rs2_d), .rd1(rd1_d), .rd2(rd2_d),
    .rd(mw_q.rd), .wd(result_w), .we(mw_q.reg_write)
  );

  assign de_in = '{ctrl: ctrl_d, rd1: rd1_d, rd2: rd2_d, imm: imm_d, pc: fd_q.pc,
                   pc_plus_4: fd_q.pc_plus_4, rs1: rs1_d, rs2: rs2_d,
                   rd: fd_q.instr[11:7]};

  stage_reg #(.payload_t(de_t), .FLUSH_VALUE('0)) de_reg (
    .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(flush_e), .d(de_in), .q(de_q)
  );

  // Execute
  execute_unit execute_unit_i (
    .de(de_q), .fwd_a(fwd_a), .fwd_b(fwd_b), .result_m(result_m), .result_w(result_w),
    .alu_result(alu_result_e), .write_data(write_data_e), .pc_src(pc_src), .pc_jump(pc_jump)
  );

  hazard_unit hazard_unit_i (
    .rs1_d(rs1_d), .rs2_d(rs2_d), .rs1_e(de_q.rs1), .rs2_e(de_q.rs2), .rd_e(de_q.rd),
    .rd_m(em_q.rd), .rd_w(mw_q.rd), .result_src_e(de_q.ctrl.result_src),
    .reg_write_m(em_q.reg_write), .reg_write_w(mw_q.reg_write), .pc_src(pc_src),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .stall_f(stall_f), .stall_d(stall_d),
    .flush_d(flush_d), .flush_e(flush_e)
  );

  assign em_in = '{reg_write: de_q.ctrl.reg_write, mem_write: de_q.ctrl.mem_write,
                   result_src: de_q.ctrl.result_src, alu_result: alu_result_e,
                   write_data: write_data_e, pc_plus_4: de_q.pc_plus_4, rd: de_q.rd};

  stage_reg #(.payload_t(em_t), .FLUSH_VALUE('0)) em_reg (
    .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0), .d(em_in), .q(em_q)
  );

  // Memory
  assign data_addr    = em_q.alu_result;
  assign data_wdata   = em_q.write_data;
  assign data_wenable = em_q.mem_write;

  // Loads never forward from here, the stall covers them
  assign result_m = (em_q.result_src == RES_PC_PLUS_4) ? em_q.pc_plus_4 : em_q.alu_result;

  assign mw_in = '{reg_write: em_q.reg_write, result_src: em_q.result_src,
                   alu_result: em_q.alu_result, read_data: data_rdata,
                   pc_plus_4: em_q.pc_plus_4, rd: em_q.rd};

  stage_reg #(.payload_t(mw_t), .FLUSH_VALUE('0)) mw_reg (
    .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0), .d(mw_in), .q(mw_q)
  );

  // Writeback
  always_comb begin
    case (mw_q.result_src)
      RES_DATA:      result_w = mw_q.read_data;
      RES_PC_PLUS_4: result_w = mw_q.pc_plus_4;
      default:       result_w = mw_q.alu_result;
    endcase
  end

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset held low for two cycles and released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== tests/rv_core_tb.sv ====
module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pkg::*;

  // Operation tables with funct3 and funct7[5] for register and immediate forms
  localparam logic [2:0] R_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  localparam logic       R_ALT [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
  localparam logic [2:0] I_F3 [9] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  localparam logic       I_ALT [9] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

  logic  clk;
  logic  rst_n;
  logic  run_rst_n;
  logic  core_rst_n;
  xlen_t instr_addr;
  xlen_t instr_data;
  xlen_t data_addr;
  xlen_t data_wdata;
  logic  data_wenable;
  xlen_t data_rdata;

  xlen_t imem [256];
  xlen_t dmem [256];
  xlen_t prog [256];
  int    prog_len;
  xlen_t exp_addr [$];
  xlen_t exp_data [$];
  logic [31:0] rng = 32'hffc7;
  int    errors = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;
  int    total_instr = 0;
  int    cycles = 0;
  int    cycle_limit = 50;

  tb_clock clock_i (.clk(clk), .rst_n(rst_n));

  assign core_rst_n = rst_n & run_rst_n;

  rv_core dut_i (
    .clk(clk), .rst_n(core_rst_n), .instr_addr(instr_addr), .instr_data(instr_data),
    .data_addr(data_addr), .data_wdata(data_wdata), .data_wenable(data_wenable),
    .data_rdata(data_rdata)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic xlen_t fill_word(input logic [7:0] idx);
    return ({24'b0, idx} * 32'h9e37_79b9) ^ {idx, ~idx, idx, 8'h5a};
  endfunction

  function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input xlen_t a, input xlen_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Instruction-level model that fills the expected store list
  function automatic int run_reference();
    xlen_t x [32];
    xlen_t mem [256];
    xlen_t pc;
    xlen_t ins;
    xlen_t a;
    xlen_t b;
    xlen_t addr;
    xlen_t next_pc;
    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_j;
    logic [2:0] f3;
    logic  taken;
    int    steps;
    foreach (x[i]) x[i] = '0;
    for (int i = 0; i < 256; i++) mem[i] = fill_word(8'(i));
    pc = '0;
    steps = 0;
    while (steps < 1000) begin
      ins = prog[pc[9:2]];
      f3 = ins[14:12];
      a = x[ins[19:15]];
      b = x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      // A jal to itself ends the program
      if (ins[6:0] == OPC_JAL && imm_j == '0) break;
      steps++;
      next_pc = pc + 32'd4;
      case (ins[6:0])
        OPC_OP:     x[ins[11:7]] = alu_ref(f3, ins[30], a, b);
        OPC_OP_IMM: x[ins[11:7]] = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);
        OPC_LUI:    x[ins[11:7]] = {ins[31:12], 12'b0};
        OPC_LOAD: begin
          addr = a + imm_i;
          x[ins[11:7]] = mem[addr[9:2]];
        end
        OPC_STORE: begin
          addr = a + imm_s;
          mem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        OPC_BRANCH: begin
          case (f3)
            3'd0:    taken = (a == b);
            3'd1:    taken = (a != b);
            3'd4:    taken = $signed(a) < $signed(b);
            default: taken = $signed(a) >= $signed(b);
          endcase
          if (taken) next_pc = pc + imm_b;
        end
        OPC_JAL: begin
          x[ins[11:7]] = pc + 32'd4;
          next_pc = pc + imm_j;
        end
        default: ;
      endcase
      x[0] = '0;
      pc = next_pc;
    end
    return steps;
  endfunction

  task automatic emit(input xlen_t ins);
    prog[prog_len] = ins;
    prog_len++;
  endtask

  task automatic alu_reg(input int k, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2);
    emit({1'b0, R_ALT[k], 5'b0, rs2, rs1, R_F3[k], rd, OPC_OP});
  endtask

  task automatic alu_imm(input int k, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
    if (I_F3[k] == 3'd1 || I_F3[k] == 3'd5) imm = {1'b0, I_ALT[k], 5'b0, imm[4:0]};
    emit({imm, rs1, I_F3[k], rd, OPC_OP_IMM});
  endtask

  task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                            input logic [11:0] off);
    emit({off[11:5], rs2, rs1, 3'b010, off[4:0], OPC_STORE});
  endtask

  task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] off);
    emit({off, rs1, 3'b010, rd, OPC_LOAD});
  endtask

  task automatic branch_to(input logic [2:0] f3, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [12:0] off);
    emit({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH});
  endtask

  task automatic jump_link(input logic [4:0] rd, input logic [20:0] off);
    emit({off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL});
  endtask

  task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
    emit({imm, rd, OPC_LUI});
  endtask

  task automatic build_alu();
    load_upper(5'd1, 20'h80f0f);
    alu_imm(0, 5'd1, 5'd1, 12'h3a5);
    load_upper(5'd2, 20'h0000f);
    alu_imm(0, 5'd2, 5'd2, 12'hff3);
    store_word(5'd1, 5'd0, 12'd0);
    for (int k = 0; k < 10; k++) begin
      alu_reg(k, 5'd3, 5'd1, 5'd2);
      store_word(5'd3, 5'd0, 12'(4 + 4 * k));
    end
    for (int k = 0; k < 9; k++) begin
      alu_imm(k, 5'd4, 5'd1, 12'(12'h8a7 + 12'd5 * 12'(k)));
      store_word(5'd4, 5'd0, 12'(64 + 4 * k));
    end
    jump_link(5'd0, '0);
  endtask

  task automatic build_forwarding();
    alu_imm(0, 5'd1, 5'd0, 12'd11);
    alu_reg(0, 5'd2, 5'd1, 5'd1);
    alu_reg(1, 5'd3, 5'd2, 5'd1);
    alu_reg(8, 5'd4, 5'd1, 5'd3);
    store_word(5'd4, 5'd0, 12'd0);
    // Result into x0 must be dropped
    alu_imm(0, 5'd0, 5'd1, 12'd99);
    alu_reg(0, 5'd5, 5'd0, 5'd2);
    store_word(5'd5, 5'd0, 12'd4);
    store_word(5'd0, 5'd0, 12'd8);
    alu_reg(5, 5'd6, 5'd5, 5'd4);
    alu_imm(0, 5'd7, 5'd6, 12'd1);
    alu_reg(9, 5'd8, 5'd7, 5'd6);
    store_word(5'd8, 5'd0, 12'd12);
    store_word(5'd7, 5'd8, 12'd16);
    jump_link(5'd0, '0);
  endtask

  task automatic build_load_use();
    alu_imm(0, 5'd1, 5'd0, 12'd123);
    alu_imm(0, 5'd2, 5'd0, 12'hff9);
    store_word(5'd1, 5'd0, 12'd32);
    load_word(5'd3, 5'd0, 12'd32);
    alu_reg(0, 5'd4, 5'd3, 5'd2);
    store_word(5'd4, 5'd0, 12'd36);
    load_word(5'd5, 5'd0, 12'd36);
    store_word(5'd5, 5'd0, 12'd40);
    load_word(5'd6, 5'd0, 12'd4);
    alu_imm(0, 5'd7, 5'd6, 12'd1);
    store_word(5'd7, 5'd0, 12'd44);
    jump_link(5'd0, '0);
  endtask

  task automatic build_control();
    alu_imm(0, 5'd1, 5'd0, 12'd5);
    alu_imm(0, 5'd2, 5'd0, 12'hffd);
    // Each taken branch skips a store to address 100
    branch_to(3'd0, 5'd1, 5'd1, 13'd8);
    store_word(5'd2, 5'd0, 12'd100);
    branch_to(3'd0, 5'd1, 5'd2, 13'd8);
    store_word(5'd1, 5'd0, 12'd0);
    branch_to(3'd1, 5'd1, 5'd2, 13'd8);
    store_word(5'd2, 5'd0, 12'd100);
    branch_to(3'd1, 5'd1, 5'd1, 13'd8);
    store_word(5'd2, 5'd0, 12'd4);
    branch_to(3'd4, 5'd2, 5'd1, 13'd8);
    store_word(5'd2, 5'd0, 12'd100);
    branch_to(3'd4, 5'd1, 5'd2, 13'd8);
    store_word(5'd1, 5'd0, 12'd8);
    branch_to(3'd5, 5'd1, 5'd2, 13'd8);
    store_word(5'd2, 5'd0, 12'd100);
    branch_to(3'd5, 5'd2, 5'd1, 13'd8);
    store_word(5'd2, 5'd0, 12'd12);
    jump_link(5'd5, 21'd8);
    store_word(5'd2, 5'd0, 12'd100);
    store_word(5'd5, 5'd0, 12'd16);
    jump_link(5'd0, '0);
  endtask

  task automatic build_random();
    logic [31:0] r;
    int n_st;
    n_st = 0;
    for (int i = 1; i < 16; i++) alu_imm(0, 5'(i), 5'd0, 12'(next_rand() >> 20));
    for (int i = 0; i < 160; i++) begin
      r = next_rand();
      if (i % 8 == 7) begin
        store_word({1'b0, r[3:0]}, 5'd0, 12'(4 * (n_st % 64)));
        n_st++;
      end else if (r[16]) begin
        alu_reg(int'(r[15:12]) % 10, {1'b0, r[3:0]}, {1'b0, r[7:4]}, {1'b0, r[11:8]});
      end else begin
        alu_imm(int'(r[15:12]) % 9, {1'b0, r[3:0]}, {1'b0, r[7:4]}, r[31:20]);
      end
    end
    jump_link(5'd0, '0);
  endtask

  task automatic run_test(input string name);
    int n;
    int errs_before;
    int n_stores;
    exp_addr.delete();
    exp_data.delete();
    n = run_reference();
    total_instr += n;
    cycle_limit = 8 * total_instr + 50;
    n_stores = exp_addr.size();
    errs_before = errors;
    @(negedge clk);
    run_rst_n = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < prog_len) ? prog[i] : NOP_INSTR;
      dmem[i] = fill_word(8'(i));
    end
    repeat (2) @(negedge clk);
    run_rst_n = 1'b1;
    while (exp_addr.size() != 0) @(negedge clk);
    // Drain so that a stray store is still seen
    repeat (8) @(negedge clk);
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %s: ok, %0d stores, %0d instructions", name, n_stores, n);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
    prog_len = 0;
  endtask

  // Memories answer on the falling edge
  always @(negedge clk) begin
    instr_data <= imem[instr_addr[9:2]];
    data_rdata <= dmem[data_addr[9:2]];
  end

  always @(posedge clk) begin
    if (core_rst_n && data_wenable) dmem[data_addr[9:2]] <= data_wdata;
  end

  // Store comparer
  always @(posedge clk) begin
    if (core_rst_n && data_wenable) begin
      if (exp_addr.size() == 0) begin
        $display("ERR %0t: unexpected store of %h at %h", $time, data_wdata, data_addr);
        errors++;
      end else begin
        if (data_addr != exp_addr[0] || data_wdata != exp_data[0]) begin
          $display("ERR %0t: store expected %h at %h, got %h at %h", $time,
                   exp_data[0], exp_addr[0], data_wdata, data_addr);
          errors++;
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the core stopped producing the expected stores after %0d cycles",
               cycles);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    run_rst_n  = 1'b0;
    instr_data = NOP_INSTR;
    data_rdata = '0;
    prog_len   = 0;
    build_alu();
    run_test("alu");
    build_forwarding();
    run_test("forwarding");
    build_load_use();
    run_test("load_use");
    build_control();
    run_test("control");
    build_random();
    run_test("random");
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/rv_pkg.sv
src/stage_reg.sv
src/decoder.sv
src/reg_file.sv
src/execute_unit.sv
src/hazard_unit.sv
src/rv_core.sv
tests/tb_clock.sv
tests/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the rv_core regression with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module rv_core_tb -f all.f; then
  echo "Verilator build failed"
  exit 1
fi

out="$(./obj_dir/Vrv_core_tb)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Regression passed" <<< "$out"; then
  exit 0
fi
exit 1
